/* bp_pkg.sv */
// ##########################################################
// shared sizes, reset vector and resolved-branch kind for
// the branch prediction front end. imported by the table,
// the return stack, the fetch pc generator and the testbench.
// ##########################################################

package bp_pkg;

    // direct-mapped branch target table.
    localparam int BT_ENTRIES = 64;
    localparam int BT_ADDR_W  = $clog2(BT_ENTRIES); // index from pc[BT_ADDR_W+1:2].
    localparam int BT_TAG_W   = 30 - BT_ADDR_W;     // remaining upper pc bits.

    // return address stack, circular.
    localparam int RAS_DEPTH = 8;

    // first fetch address out of reset, word aligned.
    localparam logic [31:0] RESET_VEC = 32'h0000_1000;

    // kind of the instruction resolved in execute.
    typedef enum logic [1:0] {
        KIND_BRANCH = 2'd0, // conditional branch.
        KIND_JUMP   = 2'd1, // plain jump, no link.
        KIND_CALL   = 2'd2, // jump that links, pushes the ras.
        KIND_RETURN = 2'd3  // pops the ras.
    } branch_kind_t;

endpackage

/* branch_table_if.sv */
// ##########################################################
// links the fetch pc generator and the return stack to the
// branch table. the fetch group carries the lookup, the
// execute group carries one resolution per cycle.
// ##########################################################

`timescale 1ns/10ps

interface branch_table_if;
    import bp_pkg::*;

    // fetch group.
    logic        new_mem_request; // request transfer this cycle.
    logic [31:0] next_pc;         // address being issued.
    logic [31:0] if_pc;           // address issued last.
    logic [31:0] predicted_pc;
    logic        use_prediction;  // tag hit on if_pc.
    logic        use_ras;         // hit entry is a return.

    // execute group fed straight from the resolve ports.
    logic         branch_ex;
    logic [31:0]  ex_pc;
    logic         branch_taken;
    logic [31:0]  jump_pc;
    logic [31:0]  njump_pc;
    branch_kind_t kind;
    logic [31:0]  dec_pc;         // what actually followed.

    // misprediction recovery.
    logic        flush;
    logic [31:0] redirect_pc;

    modport tbl (
        input  new_mem_request, next_pc, if_pc,
        input  branch_ex, ex_pc, branch_taken, jump_pc, njump_pc, kind, dec_pc,
        output predicted_pc, use_prediction, use_ras,
        output flush, redirect_pc
    );

    modport fetch (
        output new_mem_request, next_pc, if_pc,
        input  predicted_pc, use_prediction, use_ras,
        input  flush, redirect_pc
    );

    modport ras (
        input branch_ex, kind, njump_pc
    );

endinterface

/* branch_table.sv */
// ##########################################################
// direct-mapped branch target table. trained by every
// resolution, read on each fetch request, result used on
// the next cycle against if_pc. also detects mispredicts,
// raises flush and counts them by kind.
// ##########################################################

`timescale 1ns/10ps

module branch_table (
    input  logic        clk,
    input  logic        rst,
    branch_table_if.tbl bt,
    output logic [31:0] mispredict_br_count,
    output logic [31:0] mispredict_ret_count
);
    import bp_pkg::*;

    typedef struct packed {
        logic [BT_TAG_W-1:0] tag;
        logic                use_ras;
    } tag_entry_t;

    tag_entry_t  tag_ram    [BT_ENTRIES]; // tag and return flag per slot.
    logic [31:0] target_ram [BT_ENTRIES];
    logic [BT_ENTRIES-1:0] entry_valid;   // cleared in one cycle by rst.

    logic [BT_ADDR_W-1:0] ex_idx;
    logic [BT_ADDR_W-1:0] rd_idx;
    tag_entry_t           ex_entry;
    tag_entry_t           if_entry;       // read register.
    logic                 if_valid;
    logic [31:0]          if_target;
    logic [31:0]          actual_next;
    logic                 mispredict;
    logic                 is_return;

    initial begin
        for (int i = 0; i < BT_ENTRIES; i++) begin
            tag_ram[i]    = '0;
            target_ram[i] = '0;
        end
    end

    assign ex_idx  = bt.ex_pc[BT_ADDR_W+1:2];
    assign rd_idx  = bt.next_pc[BT_ADDR_W+1:2];
    assign is_return = (bt.kind == KIND_RETURN);

    assign ex_entry.tag     = bt.ex_pc[31:BT_ADDR_W+2];
    assign ex_entry.use_ras = is_return; // returns predict from the ras.

    // every resolution overwrites its slot.
    always_ff @(posedge clk) begin
        if (bt.branch_ex) begin
            tag_ram[ex_idx]    <= ex_entry;
            target_ram[ex_idx] <= actual_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (bt.branch_ex) begin
            entry_valid[ex_idx] <= 1'b1;
        end
    end

    // read register captures only on a transfer so it holds under stall.
    always_ff @(posedge clk) begin
        if (bt.new_mem_request) begin
            if_entry  <= tag_ram[rd_idx];
            if_valid  <= entry_valid[rd_idx];
            if_target <= target_ram[rd_idx];
        end
    end

    assign bt.use_prediction = if_valid && (if_entry.tag == bt.if_pc[31:BT_ADDR_W+2]);
    assign bt.use_ras        = if_entry.use_ras;
    assign bt.predicted_pc   = if_target;

    // zero latency resolution.
    assign actual_next    = bt.branch_taken ? bt.jump_pc : bt.njump_pc;
    assign mispredict     = bt.branch_ex && (bt.dec_pc != actual_next);
    assign bt.flush       = mispredict;
    assign bt.redirect_pc = actual_next; // same value as the trained target.

    always_ff @(posedge clk) begin
        if (rst) begin
            mispredict_br_count  <= '0;
            mispredict_ret_count <= '0;
        end else if (mispredict) begin
            if (is_return)
                mispredict_ret_count <= mispredict_ret_count + 32'd1;
            else
                mispredict_br_count <= mispredict_br_count + 32'd1; // branch, jump, call.
        end
    end

    // flush comes only from a resolution in execute.
    a_flush_needs_ex: assert property (@(posedge clk) disable iff (rst)
        bt.flush |-> bt.branch_ex)
        else $error("flush without branch_ex");

    // resolved pcs index from bit 2 so the low bits must be zero.
    a_ex_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        bt.branch_ex |-> (bt.ex_pc[1:0] == 2'b00))
        else $error("resolve_pc not word aligned");

endmodule

/* return_stack.sv */
// ##########################################################
// circular return address stack. resolved calls push the
// link address, resolved returns pop. no speculative
// repair; overflow drops the oldest, underflow wraps.
// ##########################################################

`timescale 1ns/10ps

module return_stack (
    input  logic        clk,
    input  logic        rst,
    branch_table_if.ras bt,
    output logic [31:0] ras_top
);
    import bp_pkg::*;

    logic [31:0]                  stack [RAS_DEPTH]; // payload, no reset.
    logic [RAS_DEPTH-1:0]         written;           // entry ever pushed.
    logic [$clog2(RAS_DEPTH)-1:0] ptr;               // points at the top.
    logic [$clog2(RAS_DEPTH)-1:0] ptr_inc;
    logic                         push;
    logic                         pop;

    assign push    = bt.branch_ex && (bt.kind == KIND_CALL);
    assign pop     = bt.branch_ex && (bt.kind == KIND_RETURN);
    assign ptr_inc = ptr + 1'b1; // wraps at RAS_DEPTH.

    // push writes above the top and moves the pointer there.
    always_ff @(posedge clk) begin
        if (push)
            stack[ptr_inc] <= bt.njump_pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr     <= '0;
            written <= '0;
        end else if (push) begin
            ptr              <= ptr_inc;
            written[ptr_inc] <= 1'b1;
        end else if (pop) begin
            ptr <= ptr - 1'b1; // underflow wraps to the far end.
        end
    end

    // untouched slots give the reset vector.
    assign ras_top = written[ptr] ? stack[ptr] : RESET_VEC;

    // kind drives push and pop, so it has to be known on a resolve.
    a_kind_known: assert property (@(posedge clk) disable iff (rst)
        bt.branch_ex |-> !$isunknown(bt.kind))
        else $error("resolve_kind unknown while branch_ex is high");

endmodule

/* fetch_pc_gen.sv */
// ##########################################################
// fetch pc register and next pc selection. issues one
// request per valid/ready transfer; priority is flush,
// ras on a return hit, table hit, then pc plus 4.
// ##########################################################

`timescale 1ns/10ps

module fetch_pc_gen (
    input  logic        clk,
    input  logic        rst,
    branch_table_if.fetch bt,
    input  logic [31:0] ras_top,
    input  logic        fetch_ready,
    output logic        fetch_valid,
    output logic [31:0] fetch_pc
);
    import bp_pkg::*;

    logic lookup_valid; // read register belongs to fetch_pc.
    logic hit;

    assign bt.new_mem_request = fetch_valid && fetch_ready;
    assign bt.if_pc           = fetch_pc;
    assign hit                = lookup_valid && bt.use_prediction;

    always_comb begin
        if (bt.flush)
            bt.next_pc = bt.redirect_pc;
        else if (hit && bt.use_ras)
            bt.next_pc = ras_top;
        else if (hit)
            bt.next_pc = bt.predicted_pc;
        else
            bt.next_pc = fetch_pc + 32'd4; // sequential.
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid  <= 1'b0;
            fetch_pc     <= RESET_VEC;
            lookup_valid <= 1'b0;  // nothing read for the reset vector.
        end else begin
            fetch_valid <= 1'b1;
            if (bt.flush || bt.new_mem_request)
                fetch_pc <= bt.next_pc; // flush moves even when stalled.
            if (bt.flush)
                lookup_valid <= 1'b0;
            else if (bt.new_mem_request)
                lookup_valid <= 1'b1;
        end
    end

    // held request must not change until accepted.
    a_pc_stable: assert property (@(posedge clk) disable iff (rst)
        (fetch_valid && !fetch_ready && !bt.flush) |=> $stable(fetch_pc))
        else $error("fetch_pc changed under back-pressure");

endmodule

/* branch_predictor_top.sv */
// ##########################################################
// branch prediction front end top level. plain ports to
// the instruction memory request and to execute; joins the
// table, return stack and fetch pc generator by interface.
// ##########################################################

`timescale 1ns/10ps

module branch_predictor_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                fetch_ready,
    output logic                fetch_valid,
    output logic [31:0]         fetch_pc,
    input  logic                resolve_valid,
    input  logic [31:0]         resolve_pc,
    input  bp_pkg::branch_kind_t resolve_kind,
    input  logic                resolve_taken,
    input  logic [31:0]         resolve_target,
    input  logic [31:0]         resolve_next_pc,
    output logic                flush,
    output logic [31:0]         redirect_pc,
    output logic [31:0]         mispredict_br_count,
    output logic [31:0]         mispredict_ret_count
);

    logic [31:0] ras_top;

    branch_table_if bt_if ();

    // execute group.
    assign bt_if.branch_ex    = resolve_valid;
    assign bt_if.ex_pc        = resolve_pc;
    assign bt_if.branch_taken = resolve_taken;
    assign bt_if.jump_pc      = resolve_target;
    assign bt_if.njump_pc     = resolve_pc + 32'd4; // fall-through and link address.
    assign bt_if.kind         = resolve_kind;
    assign bt_if.dec_pc       = resolve_next_pc;

    assign flush       = bt_if.flush;
    assign redirect_pc = bt_if.redirect_pc;

    branch_table u_branch_table (
        .clk                  (clk),
        .rst                  (rst),
        .bt                   (bt_if.tbl),
        .mispredict_br_count  (mispredict_br_count),
        .mispredict_ret_count (mispredict_ret_count)
    );

    return_stack u_return_stack (
        .clk     (clk),
        .rst     (rst),
        .bt      (bt_if.ras),
        .ras_top (ras_top)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .bt          (bt_if.fetch),
        .ras_top     (ras_top),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc)
    );

endmodule

/* bp_checker.sv */
// ##########################################################
// watches the predictor ports at the falling edge, checks
// them against a cycle model of table, return stack and
// fetch pc, then steps the model to the next rising edge.
// ##########################################################

`timescale 1ns/10ps

module bp_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_ready,
    input  logic                 fetch_valid,
    input  logic [31:0]          fetch_pc,
    input  logic                 resolve_valid,
    input  logic [31:0]          resolve_pc,
    input  bp_pkg::branch_kind_t resolve_kind,
    input  logic                 resolve_taken,
    input  logic [31:0]          resolve_target,
    input  logic [31:0]          resolve_next_pc,
    input  logic                 flush,
    input  logic [31:0]          redirect_pc,
    input  logic [31:0]          mispredict_br_count,
    input  logic [31:0]          mispredict_ret_count,
    input  logic                 done,
    output int                   errors,
    output logic                 final_done
);
    import bp_pkg::*;

    logic [31:0]                  m_tag    [BT_ENTRIES]; // pc >> (index + 2).
    logic [31:0]                  m_target [BT_ENTRIES];
    logic                         m_ret    [BT_ENTRIES]; // entry predicts from ras.
    logic [BT_ENTRIES-1:0]        m_valid;
    logic [31:0]                  m_stack  [RAS_DEPTH];
    logic [RAS_DEPTH-1:0]         m_written;
    logic [$clog2(RAS_DEPTH)-1:0] m_ptr;
    logic                         cap_valid;             // captured lookup.
    logic                         cap_ret;
    logic [31:0]                  cap_tag;
    logic [31:0]                  cap_target;
    logic                         m_lookup;              // capture belongs to m_pc.
    logic                         m_fv;
    logic [31:0]                  m_pc;
    logic [31:0]                  m_br;
    logic [31:0]                  m_retc;
    logic [31:0]                  act_next;
    logic [31:0]                  exp_next;
    logic [31:0]                  ras_top;
    logic                         exp_flush;
    logic                         hit;
    logic                         req;
    logic [BT_ADDR_W-1:0]         idx;

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            errors     = 0;
            final_done = 1'b0;
            m_valid    = '0;
            m_written  = '0;
            m_ptr      = '0;
            m_br       = '0;
            m_retc     = '0;
            m_pc       = RESET_VEC;
            m_fv       = 1'b0;
            m_lookup   = 1'b0;
        end else begin
            compare_word("fetch_valid", {31'd0, m_fv}, {31'd0, fetch_valid});
            compare_word("fetch_pc", m_pc, fetch_pc);
            compare_word("mispredict_br_count", m_br, mispredict_br_count);
            compare_word("mispredict_ret_count", m_retc, mispredict_ret_count);

            // resolution, same cycle.
            act_next  = resolve_taken ? resolve_target : resolve_pc + 32'd4;
            exp_flush = resolve_valid && (resolve_next_pc != act_next);
            compare_word("flush", {31'd0, exp_flush}, {31'd0, flush});
            if (exp_flush)
                compare_word("redirect_pc", act_next, redirect_pc);

            // next fetch address by priority.
            ras_top = m_written[m_ptr] ? m_stack[m_ptr] : RESET_VEC;
            hit = m_lookup && cap_valid && (cap_tag == (m_pc >> (BT_ADDR_W + 2)));
            if (exp_flush)
                exp_next = act_next;
            else if (hit && cap_ret)
                exp_next = ras_top;
            else if (hit)
                exp_next = cap_target;
            else
                exp_next = m_pc + 32'd4;
            req = m_fv && fetch_ready;

            // lookup reads the table before this edge's training.
            if (req) begin
                idx        = exp_next[BT_ADDR_W+1:2];
                cap_valid  = m_valid[idx];
                cap_tag    = m_tag[idx];
                cap_ret    = m_ret[idx];
                cap_target = m_target[idx];
            end
            if (resolve_valid) begin
                idx           = resolve_pc[BT_ADDR_W+1:2];
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = resolve_pc >> (BT_ADDR_W + 2);
                m_ret[idx]    = (resolve_kind == KIND_RETURN);
                m_target[idx] = act_next;
                if (resolve_kind == KIND_CALL) begin
                    m_ptr            = m_ptr + 1'b1;  // wraps, oldest lost.
                    m_stack[m_ptr]   = resolve_pc + 32'd4;
                    m_written[m_ptr] = 1'b1;
                end else if (resolve_kind == KIND_RETURN) begin
                    m_ptr = m_ptr - 1'b1;
                end
            end
            if (exp_flush && resolve_kind == KIND_RETURN)
                m_retc = m_retc + 32'd1;
            else if (exp_flush)
                m_br = m_br + 32'd1;
            if (exp_flush || req)
                m_pc = exp_next;
            if (exp_flush)
                m_lookup = 1'b0;  // no lookup for the redirect target yet.
            else if (req)
                m_lookup = 1'b1;
            m_fv = 1'b1;

            // totals once the stimulus has stopped.
            if (done && !final_done) begin
                compare_word("mispredict_br_count total", m_br, mispredict_br_count);
                compare_word("mispredict_ret_count total", m_retc, mispredict_ret_count);
                $display("mispredicts: branch kinds %0d, returns %0d", m_br, m_retc);
                final_done = 1'b1;
            end
        end
    end

endmodule

/* tb_branch_predictor.sv */
// ##########################################################
// testbench top for the branch prediction front end.
// drives seeded random fetch back-pressure and resolutions
// from a small pc pool; bp_checker does all the comparing.
// ##########################################################

`timescale 1ns/10ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int          NUM_CYCLES = 4000;
    localparam logic [31:0] SEED       = 32'h1a622abb;

    logic         clk;
    logic         rst;
    logic         fetch_ready;
    logic         fetch_valid;
    logic [31:0]  fetch_pc;
    logic         resolve_valid;
    logic [31:0]  resolve_pc;
    branch_kind_t resolve_kind;
    logic         resolve_taken;
    logic [31:0]  resolve_target;
    logic [31:0]  resolve_next_pc;
    logic         flush;
    logic [31:0]  redirect_pc;
    logic [31:0]  mispredict_br_count;
    logic [31:0]  mispredict_ret_count;
    logic         done;        // stimulus finished.
    logic         final_done;  // checker ran its totals.
    int           errors;
    int           timeouts;
    int           seed_status;
    logic         ok;
    logic [31:0]  pool [12];   // aligned pcs, some share an index.

    branch_predictor_top dut (.*);

    bp_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 0x1100 and 0x1200 alias 0x1000, 0x1104 aliases 0x1004.
    task automatic load_pool();
        pool[0]  = 32'h0000_1000;
        pool[1]  = 32'h0000_1004;
        pool[2]  = 32'h0000_1008;
        pool[3]  = 32'h0000_100c;
        pool[4]  = 32'h0000_1010;
        pool[5]  = 32'h0000_1018;
        pool[6]  = 32'h0000_1024;
        pool[7]  = 32'h0000_1040;
        pool[8]  = 32'h0000_1080;
        pool[9]  = 32'h0000_1100;
        pool[10] = 32'h0000_1104;
        pool[11] = 32'h0000_1200;
    endtask

    // one cycle of random stimulus, called on the rising edge.
    task automatic drive_cycle();
        logic [31:0]  rnd;
        logic [31:0]  pc;
        logic [31:0]  target;
        logic [31:0]  correct;
        logic         taken;
        branch_kind_t kind;
        rnd = $urandom();
        fetch_ready <= (rnd % 100) < 70;   // about 70 % ready.
        rnd = $urandom();
        resolve_valid <= (rnd % 100) < 30;
        pc = pool[4'($urandom() % 12)];
        target = pool[4'($urandom() % 12)];
        rnd = $urandom();
        kind = branch_kind_t'(rnd[1:0]);
        taken = (kind == KIND_BRANCH) ? rnd[2] : 1'b1; // only branches fall through.
        correct = taken ? target : pc + 32'd4;
        rnd = $urandom();
        resolve_pc      <= pc;
        resolve_kind    <= kind;
        resolve_taken   <= taken;
        resolve_target  <= target;
        resolve_next_pc <= rnd[0] ? correct : pool[4'(rnd[31:1] % 12)];
    endtask

    task automatic wait_for_fetch_valid(output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 20) begin
            @(negedge clk);
            seen = fetch_valid;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: fetch_valid never went high after reset release");
        end
    endtask

    task automatic wait_for_checker(output logic seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 20) begin
            @(negedge clk);
            seen = final_done;
            n++;
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: checker never finished its closing compare");
        end
    endtask

    initial begin
        seed_status = $urandom(SEED);  // seed once.
        rst             = 1'b1;
        fetch_ready     = 1'b0;
        resolve_valid   = 1'b0;
        resolve_pc      = RESET_VEC;
        resolve_kind    = KIND_BRANCH;
        resolve_taken   = 1'b0;
        resolve_target  = RESET_VEC;
        resolve_next_pc = RESET_VEC;
        done            = 1'b0;
        timeouts        = 0;
        ok              = 1'b0;
        load_pool();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        wait_for_fetch_valid(ok);
        if (ok) begin
            repeat (NUM_CYCLES) begin
                @(posedge clk);
                drive_cycle();
            end
            @(posedge clk);
            resolve_valid <= 1'b0;  // quiet pipe for the totals.
            fetch_ready   <= 1'b1;
            done          <= 1'b1;
            wait_for_checker(ok);
        end
        $display("errors: value mismatches %0d, timeouts %0d", errors, timeouts);
        if (ok && errors == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* branch_predictor_top.f */
bp_pkg.sv
branch_table_if.sv
branch_table.sv
return_stack.sv
fetch_pc_gen.sv
branch_predictor_top.sv
bp_checker.sv
tb_branch_predictor.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f branch_predictor_top.f \
    --top-module tb_branch_predictor \
    -o sim_branch_predictor

./obj_dir/sim_branch_predictor > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi

echo "run passed"
